// ==== Makefile ====
TOP := tb_cpu_memory

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== rtl/cpu_dcache.sv ====
`timescale 1ns/1ps

module cpu_dcache #(
	parameter int DCACHE_LINES = 64
) (
	input  logic        i_clock,
	input  logic        i_rst_n,

	input  logic        i_req_valid,
	input  logic        i_req_write,
	input  logic        i_req_flush,
	input  logic [31:0] i_req_address,
	input  logic [31:0] i_req_wdata,
	output logic        o_req_ready,
	output logic [31:0] o_req_rdata,

	output logic        o_bus_request,
	output logic        o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(DCACHE_LINES);
	localparam int LINE_TAG_BITS = 30 - INDEX_BITS;

	typedef enum logic [1:0] {
		C_IDLE,
		C_BUS,
		C_FLUSH
	} state_t;

	state_t                    state;
	logic [DCACHE_LINES-1:0]   valid_bits;
	logic [LINE_TAG_BITS-1:0]  tag_array [DCACHE_LINES];
	logic [31:0]               data_array [DCACHE_LINES];
	logic [INDEX_BITS-1:0]     flush_index;

	logic [31:0]               lookup_address;
	logic [INDEX_BITS-1:0]     line_index;
	logic [LINE_TAG_BITS-1:0]  line_tag;
	logic                      cacheable;
	logic                      hit;
	logic                      accept;
	logic                      read_hit;
	logic                      fill_en;

	// request fields stay stable, the latched bus address serves while on the bus
	assign lookup_address = (state == C_BUS) ? o_bus_address : i_req_address;
	assign line_index     = lookup_address[INDEX_BITS+1:2];
	assign line_tag       = lookup_address[31:INDEX_BITS+2];
	assign cacheable      = (lookup_address[31:28] == cpu_pkg::CACHEABLE_REGION);
	assign hit            = cacheable & valid_bits[line_index] & (tag_array[line_index] == line_tag);

	assign accept   = (state == C_IDLE) & i_req_valid & ~o_req_ready;	// skip the ready cycle
	assign read_hit = accept & ~i_req_flush & ~i_req_write & hit;
	assign fill_en  = (state == C_BUS) & i_bus_ready & cacheable & (~o_bus_rw | hit);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= C_IDLE;
			valid_bits    <= '0;
			flush_index   <= '0;
			o_req_ready   <= 1'b0;
			o_bus_request <= 1'b0;
			o_bus_rw      <= 1'b0;
		end else begin
			o_req_ready <= 1'b0;	// single cycle pulse
			case (state)
				C_IDLE: begin
					if (accept) begin
						if (i_req_flush) begin
							flush_index <= '0;
							state       <= C_FLUSH;
						end else if (read_hit) begin
							o_req_ready <= 1'b1;
						end else begin
							o_bus_request <= 1'b1;
							o_bus_rw      <= i_req_write;
							state         <= C_BUS;
						end
					end
				end
				C_BUS: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_bus_rw      <= 1'b0;
						o_req_ready   <= 1'b1;
						if (fill_en)
							valid_bits[line_index] <= 1'b1;
						state <= C_IDLE;
					end
				end
				C_FLUSH: begin
					valid_bits[flush_index] <= 1'b0;	// one line per cycle
					if (flush_index == INDEX_BITS'(DCACHE_LINES - 1)) begin
						o_req_ready <= 1'b1;
						state       <= C_IDLE;
					end else begin
						flush_index <= flush_index + 1'b1;
					end
				end
				default: state <= C_IDLE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// arrays and data path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge i_clock) begin
		if (fill_en) begin
			tag_array[line_index]  <= line_tag;
			data_array[line_index] <= o_bus_rw ? o_bus_wdata : i_bus_rdata;	// write hit or fill
		end
		if (read_hit)
			o_req_rdata <= data_array[line_index];
		else if (state == C_BUS && i_bus_ready)
			o_req_rdata <= i_bus_rdata;
		if (accept) begin
			o_bus_address <= i_req_address;
			o_bus_wdata   <= i_req_wdata;
		end
	end

endmodule

// ==== rtl/cpu_lane_align.sv ====
`timescale 1ns/1ps

module cpu_lane_align (
	input  logic [1:0]             i_byte_index,
	input  cpu_pkg::mem_width_t    i_width,
	input  logic                   i_signed,
	input  logic [31:0]            i_read_word,
	input  logic [31:0]            i_old_word,
	input  logic [31:0]            i_store_data,
	output logic [31:0]            o_load_value,
	output logic [31:0]            o_store_word
);

	logic [31:0] read_shifted;
	logic [31:0] store_lanes;
	logic [3:0]  store_mask;

	assign read_shifted = i_read_word >> {i_byte_index, 3'b000};	// lane down to bit 0

	always_comb begin
		case (i_width)
			cpu_pkg::MEMW_1: o_load_value = {{24{i_signed & read_shifted[7]}}, read_shifted[7:0]};
			cpu_pkg::MEMW_2: o_load_value = {{16{i_signed & read_shifted[15]}}, read_shifted[15:0]};
			default:         o_load_value = i_read_word;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// store merge, data copied to every lane and the mask picks the target
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (i_width)
			cpu_pkg::MEMW_1: begin
				store_lanes = {4{i_store_data[7:0]}};
				store_mask  = 4'b0001 << i_byte_index;
			end
			cpu_pkg::MEMW_2: begin
				store_lanes = {2{i_store_data[15:0]}};
				store_mask  = 4'b0011 << i_byte_index;	// index is 0 or 2 here
			end
			default: begin
				store_lanes = i_store_data;
				store_mask  = 4'b1111;
			end
		endcase

		for (int lane = 0; lane < 4; lane++) begin
			o_store_word[lane*8 +: 8] = store_mask[lane] ? store_lanes[lane*8 +: 8]
			                                             : i_old_word[lane*8 +: 8];
		end
	end

endmodule

// ==== rtl/cpu_memory_stage.sv ====
`timescale 1ns/1ps

module cpu_memory_stage (
	input  logic                          i_clock,
	input  logic                          i_rst_n,

	// pipeline side
	input  logic [cpu_pkg::TAG_BITS-1:0]  i_tag,
	input  logic                          i_mem_read,
	input  logic                          i_mem_write,
	input  logic                          i_mem_flush,
	input  cpu_pkg::mem_width_t           i_mem_width,
	input  logic [31:0]                   i_mem_address,
	input  logic [31:0]                   i_rd,
	input  logic [cpu_pkg::REG_BITS-1:0]  i_inst_rd,
	input  logic [cpu_pkg::REG_BITS-1:0]  i_mem_inst_rd,
	output logic [cpu_pkg::TAG_BITS-1:0]  o_tag,
	output logic [31:0]                   o_rd,
	output logic [cpu_pkg::REG_BITS-1:0]  o_inst_rd,
	output logic                          o_busy,

	// cache request
	output logic                          o_req_valid,
	output logic                          o_req_write,
	output logic                          o_req_flush,
	output logic [31:0]                   o_req_address,
	output logic [31:0]                   o_req_wdata,
	input  logic                          i_req_ready,
	input  logic [31:0]                   i_req_rdata,

	// lane align unit
	output logic [1:0]                    o_byte_index,
	input  logic [31:0]                   i_load_value,
	input  logic [31:0]                   i_store_word,
	output logic [31:0]                   o_rmw_word
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_WRITE_WORD,
		S_RMW_READ,
		S_RMW_WRITE,
		S_FLUSH
	} state_t;

	state_t state;
	logic   tag_change;
	logic   mem_op;
	logic   retire;

	assign tag_change    = (i_tag != o_tag);
	assign mem_op        = i_mem_read | i_mem_write | i_mem_flush;
	assign o_busy        = tag_change & mem_op;
	assign o_req_address = {i_mem_address[31:2], 2'b00};
	assign o_byte_index  = i_mem_address[1:0];

	// a memory op finishes on its last cache ready pulse
	always_comb begin
		case (state)
			S_IDLE:     retire = tag_change & ~mem_op;	// pass-through op
			S_RMW_READ: retire = 1'b0;	// merged write still to come
			default:    retire = i_req_ready;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= S_IDLE;
			o_req_valid <= 1'b0;
			o_req_write <= 1'b0;
			o_req_flush <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (tag_change) begin
						if (i_mem_read) begin
							o_req_valid <= 1'b1;
							state       <= S_READ;
						end else if (i_mem_write) begin
							o_req_valid <= 1'b1;
							if (i_mem_width == cpu_pkg::MEMW_4) begin
								o_req_write <= 1'b1;
								state       <= S_WRITE_WORD;
							end else begin
								state <= S_RMW_READ;	// fetch the old word first
							end
						end else if (i_mem_flush) begin
							o_req_valid <= 1'b1;
							o_req_flush <= 1'b1;
							state       <= S_FLUSH;
						end
					end
				end
				S_RMW_READ: begin
					if (i_req_ready) begin
						o_req_valid <= 1'b0;
						state       <= S_RMW_WRITE;
					end
				end
				S_RMW_WRITE: begin
					if (i_req_ready) begin
						o_req_valid <= 1'b0;
						o_req_write <= 1'b0;
						state       <= S_IDLE;
					end else if (!o_req_valid) begin
						o_req_valid <= 1'b1;	// merged word goes out
						o_req_write <= 1'b1;
					end
				end
				default: begin	// read, word write, flush
					if (i_req_ready) begin
						o_req_valid <= 1'b0;
						o_req_write <= 1'b0;
						o_req_flush <= 1'b0;
						state       <= S_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == S_IDLE)
			o_req_wdata <= i_rd;
		else if (state == S_RMW_WRITE && !o_req_valid)
			o_req_wdata <= i_store_word;
		if (state == S_RMW_READ && i_req_ready)
			o_rmw_word <= i_req_rdata;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// retire register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			o_tag <= '0;
		else if (retire)
			o_tag <= i_tag;
	end

	always_ff @(posedge i_clock) begin
		if (retire) begin
			if (state == S_READ) begin
				o_rd      <= i_load_value;
				o_inst_rd <= i_mem_inst_rd;
			end else begin
				o_rd      <= i_rd;
				o_inst_rd <= i_inst_rd;
			end
		end
	end

endmodule

// ==== rtl/cpu_memory_top.sv ====
`timescale 1ns/1ps

module cpu_memory_top #(
	parameter int DCACHE_LINES = 64
) (
	input  logic                          i_clock,
	input  logic                          i_rst_n,

	// pipeline
	input  logic [cpu_pkg::TAG_BITS-1:0]  i_tag,
	input  logic                          i_mem_read,
	input  logic                          i_mem_write,
	input  logic                          i_mem_flush,
	input  cpu_pkg::mem_width_t           i_mem_width,
	input  logic                          i_mem_signed,
	input  logic [31:0]                   i_mem_address,
	input  logic [31:0]                   i_rd,
	input  logic [cpu_pkg::REG_BITS-1:0]  i_inst_rd,
	input  logic [cpu_pkg::REG_BITS-1:0]  i_mem_inst_rd,
	output logic [cpu_pkg::TAG_BITS-1:0]  o_tag,
	output logic [31:0]                   o_rd,
	output logic [cpu_pkg::REG_BITS-1:0]  o_inst_rd,
	output logic                          o_busy,

	// bus
	output logic                          o_bus_request,
	output logic                          o_bus_rw,
	output logic [31:0]                   o_bus_address,
	output logic [31:0]                   o_bus_wdata,
	input  logic                          i_bus_ready,
	input  logic [31:0]                   i_bus_rdata
);

	logic        req_valid;
	logic        req_write;
	logic        req_flush;
	logic [31:0] req_address;
	logic [31:0] req_wdata;
	logic        req_ready;
	logic [31:0] req_rdata;

	logic [1:0]  byte_index;
	logic [31:0] load_value;
	logic [31:0] store_word;
	logic [31:0] rmw_word;

	cpu_memory_stage u_stage (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_tag          (i_tag),
		.i_mem_read     (i_mem_read),
		.i_mem_write    (i_mem_write),
		.i_mem_flush    (i_mem_flush),
		.i_mem_width    (i_mem_width),
		.i_mem_address  (i_mem_address),
		.i_rd           (i_rd),
		.i_inst_rd      (i_inst_rd),
		.i_mem_inst_rd  (i_mem_inst_rd),
		.o_tag          (o_tag),
		.o_rd           (o_rd),
		.o_inst_rd      (o_inst_rd),
		.o_busy         (o_busy),
		.o_req_valid    (req_valid),
		.o_req_write    (req_write),
		.o_req_flush    (req_flush),
		.o_req_address  (req_address),
		.o_req_wdata    (req_wdata),
		.i_req_ready    (req_ready),
		.i_req_rdata    (req_rdata),
		.o_byte_index   (byte_index),
		.i_load_value   (load_value),
		.i_store_word   (store_word),
		.o_rmw_word     (rmw_word)
	);

	cpu_lane_align u_align (
		.i_byte_index   (byte_index),
		.i_width        (i_mem_width),
		.i_signed       (i_mem_signed),
		.i_read_word    (req_rdata),
		.i_old_word     (rmw_word),
		.i_store_data   (i_rd),	// store data rides on the result field
		.o_load_value   (load_value),
		.o_store_word   (store_word)
	);

	cpu_dcache #(
		.DCACHE_LINES   (DCACHE_LINES)
	) u_dcache (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_req_valid    (req_valid),
		.i_req_write    (req_write),
		.i_req_flush    (req_flush),
		.i_req_address  (req_address),
		.i_req_wdata    (req_wdata),
		.o_req_ready    (req_ready),
		.o_req_rdata    (req_rdata),
		.o_bus_request  (o_bus_request),
		.o_bus_rw       (o_bus_rw),
		.o_bus_address  (o_bus_address),
		.o_bus_wdata    (o_bus_wdata),
		.i_bus_ready    (i_bus_ready),
		.i_bus_rdata    (i_bus_rdata)
	);

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// access width of a load or store
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		MEMW_1 = 2'd0,	// byte
		MEMW_2 = 2'd1,	// halfword
		MEMW_4 = 2'd2	// full word
	} mem_width_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pipeline field widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the tag wraps, a change against the retired tag marks a new op
	localparam int TAG_BITS = 4;

	localparam int REG_BITS = 5;	// register file index

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// sdram sits at top nibble 2, the only region worth caching
	localparam logic [3:0] CACHEABLE_REGION = 4'h2;

endpackage

// ==== test/tb_bus_memory.sv ====
`timescale 1ns/1ps

module tb_bus_memory (
	input  logic        i_clock,
	input  logic        i_rst_n,
	input  logic        i_request,
	input  logic        i_rw,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic        o_ready,
	output logic [31:0] o_rdata
);

	logic [31:0] mem [logic [29:0]];	// word storage by word index
	int          read_count;
	int          wait_cycles;
	logic        serving;

	// a word never written mixes every address bit
	function automatic logic [31:0] fill_word(input logic [31:0] address);
		return {address[15:0], address[31:16]} ^ 32'h6b2d_91c3;
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] address);
		if (mem.exists(address[31:2]))
			return mem[address[31:2]];
		return fill_word({address[31:2], 2'b00});
	endfunction

	task automatic write_word(input logic [31:0] address, input logic [31:0] data);
		mem[address[31:2]] = data;	// backdoor write without a bus cycle
	endtask

	always @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready     <= 1'b0;
			o_rdata     <= '0;
			serving     <= 1'b0;
			wait_cycles <= 0;
			read_count  <= 0;
		end else begin
			o_ready <= 1'b0;
			if (!serving && i_request && !o_ready) begin
				serving     <= 1'b1;
				wait_cycles <= 1 + int'($urandom % 4);	// 1 to 4 cycles
			end else if (serving) begin
				if (wait_cycles <= 1) begin
					serving <= 1'b0;
					o_ready <= 1'b1;
					if (i_rw) begin
						mem[i_address[31:2]] = i_wdata;
					end else begin
						o_rdata    <= read_word(i_address);
						read_count <= read_count + 1;
					end
				end else begin
					wait_cycles <= wait_cycles - 1;
				end
			end
		end
	end

endmodule

// ==== test/tb_cpu_memory.sv ====
`timescale 1ns/1ps

module tb_cpu_memory;

	localparam int NUM_OPS   = 90;
	localparam int MAX_CYCLE = NUM_OPS * 40 + 100;
	localparam logic [31:0] CACHED_BASE   = 32'h2000_0000;
	localparam logic [31:0] UNCACHED_BASE = 32'h1000_0100;

	logic                          i_clock;
	logic                          i_rst_n;
	logic [cpu_pkg::TAG_BITS-1:0]  i_tag;
	logic                          i_mem_read;
	logic                          i_mem_write;
	logic                          i_mem_flush;
	cpu_pkg::mem_width_t           i_mem_width;
	logic                          i_mem_signed;
	logic [31:0]                   i_mem_address;
	logic [31:0]                   i_rd;
	logic [cpu_pkg::REG_BITS-1:0]  i_inst_rd;
	logic [cpu_pkg::REG_BITS-1:0]  i_mem_inst_rd;
	logic [cpu_pkg::TAG_BITS-1:0]  o_tag;
	logic [31:0]                   o_rd;
	logic [cpu_pkg::REG_BITS-1:0]  o_inst_rd;
	logic                          o_busy;
	logic                          bus_request;
	logic                          bus_rw;
	logic [31:0]                   bus_address;
	logic [31:0]                   bus_wdata;
	logic                          bus_ready;
	logic [31:0]                   bus_rdata;

	logic [31:0]                   shadow [logic [31:0]];	// expected memory by word address
	logic                          pending;
	logic [cpu_pkg::TAG_BITS-1:0]  exp_tag;
	logic [cpu_pkg::REG_BITS-1:0]  exp_inst_rd;
	logic [31:0]                   exp_rd;
	int                            cycles;

	cpu_memory_top #(.DCACHE_LINES(64)) i_dut (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_tag(i_tag), .i_mem_read(i_mem_read), .i_mem_write(i_mem_write),
		.i_mem_flush(i_mem_flush), .i_mem_width(i_mem_width), .i_mem_signed(i_mem_signed),
		.i_mem_address(i_mem_address), .i_rd(i_rd), .i_inst_rd(i_inst_rd),
		.i_mem_inst_rd(i_mem_inst_rd), .o_tag(o_tag), .o_rd(o_rd),
		.o_inst_rd(o_inst_rd), .o_busy(o_busy),
		.o_bus_request(bus_request), .o_bus_rw(bus_rw), .o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata), .i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata)
	);

	tb_bus_memory u_memory (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_request(bus_request), .i_rw(bus_rw), .i_address(bus_address),
		.i_wdata(bus_wdata), .o_ready(bus_ready), .o_rdata(bus_rdata)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] load_extract(input logic [31:0] word,
		input logic [1:0] index, input cpu_pkg::mem_width_t width, input logic sgn);
		logic [7:0]  b;
		logic [15:0] h;
		b = word[index*8 +: 8];
		h = index[1] ? word[31:16] : word[15:0];
		case (width)
			cpu_pkg::MEMW_1: return sgn ? {{24{b[7]}}, b} : {24'h0, b};
			cpu_pkg::MEMW_2: return sgn ? {{16{h[15]}}, h} : {16'h0, h};
			default:         return word;
		endcase
	endfunction

	function automatic logic [31:0] store_merge(input logic [31:0] old,
		input logic [31:0] data, input logic [1:0] index, input cpu_pkg::mem_width_t width);
		logic [31:0] word;
		word = old;
		case (width)
			cpu_pkg::MEMW_1: word[index*8 +: 8] = data[7:0];
			cpu_pkg::MEMW_2: word[index[1]*16 +: 16] = data[15:0];
			default:         word = data;
		endcase
		return word;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_result(input logic [cpu_pkg::TAG_BITS-1:0] tag,
		input logic [cpu_pkg::REG_BITS-1:0] rd_index, input logic [31:0] value);
		if (o_tag !== tag || o_inst_rd !== rd_index || o_rd !== value) begin
			$display("ERROR at %0t: got tag %0h rd %0d value %08h, want %0h %0d %08h",
				$time, o_tag, o_inst_rd, o_rd, tag, rd_index, value);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic check_bus_reads(input int count);
		if (u_memory.read_count != count) begin
			$display("ERROR at %0t: %0d bus reads, expected %0d",
				$time, u_memory.read_count, count);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic check_busy(input logic expected);
		if (o_busy !== expected) begin
			$display("ERROR at %0t: o_busy %b, expected %b", $time, o_busy, expected);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	// results sampled on the falling edge
	always @(negedge i_clock) begin
		if (pending && o_tag == i_tag) begin
			check_result(exp_tag, exp_inst_rd, exp_rd);
			pending = 1'b0;
		end
	end

	always @(posedge i_clock) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLE) begin
			$display("timeout: no result after %0d cycles", cycles);
			$display("Regression failed");
			$fatal(1);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic issue(input logic rd_en, input logic wr_en, input logic fl_en,
		input cpu_pkg::mem_width_t width, input logic sgn, input logic [31:0] address,
		input logic [31:0] rd, input logic [4:0] inst_rd, input logic [4:0] mem_inst_rd,
		input logic [31:0] expected);
		@(posedge i_clock);
		#1;
		i_tag         = i_tag + 1'b1;	// wraps and still differs from the retired tag
		i_mem_read    = rd_en;
		i_mem_write   = wr_en;
		i_mem_flush   = fl_en;
		i_mem_width   = width;
		i_mem_signed  = sgn;
		i_mem_address = address;
		i_rd          = rd;
		i_inst_rd     = inst_rd;
		i_mem_inst_rd = mem_inst_rd;
		exp_tag       = i_tag;
		exp_inst_rd   = rd_en ? mem_inst_rd : inst_rd;
		exp_rd        = expected;
		pending       = 1'b1;
		@(negedge i_clock);
		check_busy(rd_en | wr_en | fl_en);
		while (pending)
			@(negedge i_clock);
	endtask

	task automatic do_load(input logic [31:0] address, input cpu_pkg::mem_width_t width,
		input logic sgn);
		logic [31:0] expected;
		expected = load_extract(shadow[{address[31:2], 2'b00}], address[1:0], width, sgn);
		issue(1, 0, 0, width, sgn, address, $urandom, 5'd3, 5'($urandom), expected);
	endtask

	task automatic do_store(input logic [31:0] address, input cpu_pkg::mem_width_t width,
		input logic [31:0] data);
		logic [31:0] word_address;
		word_address = {address[31:2], 2'b00};
		shadow[word_address] = store_merge(shadow[word_address], data, address[1:0], width);
		issue(0, 1, 0, width, 0, address, data, 5'($urandom), 5'd7, data);
	endtask

	task automatic do_flush();
		logic [31:0] rd;
		rd = $urandom;
		issue(0, 0, 1, cpu_pkg::MEMW_4, 0, 32'h0, rd, 5'd9, 5'd1, rd);
	endtask

	task automatic do_alu();
		logic [31:0] rd;
		rd = $urandom;
		issue(0, 0, 0, cpu_pkg::MEMW_4, 0, $urandom, rd, 5'($urandom), 5'($urandom), rd);
	endtask

	function automatic logic [31:0] pool_address(input int k, input logic cached);
		return (cached ? CACHED_BASE : UNCACHED_BASE) + 32'(k * 4);
	endfunction

	initial begin
		logic [31:0] address;
		logic [31:0] fresh;
		int          reads;
		void'($urandom(32'hdd62));
		cycles = 0;
		pending = 1'b0;
		i_rst_n = 1'b0;
		i_tag = '0;
		i_mem_read = 1'b0;
		i_mem_write = 1'b0;
		i_mem_flush = 1'b0;
		i_mem_width = cpu_pkg::MEMW_4;
		i_mem_signed = 1'b0;
		i_mem_address = '0;
		i_rd = '0;
		i_inst_rd = '0;
		i_mem_inst_rd = '0;
		for (int k = 0; k < 16; k++) begin
			for (int c = 0; c < 2; c++) begin
				address = pool_address(k, c[0]);
				shadow[address] = $urandom;
				u_memory.write_word(address, shadow[address]);
			end
		end
		shadow[CACHED_BASE] = 32'h7f8f_80ff;	// both sign states in every lane width
		u_memory.write_word(CACHED_BASE, 32'h7f8f_80ff);
		repeat (3) @(posedge i_clock);
		#1 i_rst_n = 1'b1;

		// every width, signedness and byte index
		for (int c = 0; c < 2; c++) begin
			address = pool_address(0, c[0]);
			for (int s = 0; s < 2; s++) begin
				for (int i = 0; i < 4; i++)
					do_load(address + 32'(i), cpu_pkg::MEMW_1, s[0]);
				do_load(address, cpu_pkg::MEMW_2, s[0]);
				do_load(address + 32'd2, cpu_pkg::MEMW_2, s[0]);
				do_load(address, cpu_pkg::MEMW_4, s[0]);
			end
		end

		// narrow and word stores, each read back as a word
		for (int n = 0; n < 24; n++) begin
			address = pool_address(int'($urandom % 8), $urandom % 2 == 0);
			case ($urandom % 3)
				0: do_store(address + 32'($urandom % 4), cpu_pkg::MEMW_1, $urandom);
				1: do_store(address + 32'(($urandom % 2) * 2), cpu_pkg::MEMW_2, $urandom);
				default: do_store(address, cpu_pkg::MEMW_4, $urandom);
			endcase
			do_load(address, cpu_pkg::MEMW_4, 0);
		end

		// bus read counts, cached against uncached
		address = pool_address(10, 1);
		do_load(address, cpu_pkg::MEMW_4, 0);
		reads = u_memory.read_count;
		do_load(address, cpu_pkg::MEMW_4, 0);
		check_bus_reads(reads);
		address = pool_address(10, 0);
		do_load(address, cpu_pkg::MEMW_4, 0);
		check_bus_reads(reads + 1);
		do_load(address, cpu_pkg::MEMW_4, 0);
		check_bus_reads(reads + 2);

		// stale line until a flush
		address = pool_address(12, 1);
		do_load(address, cpu_pkg::MEMW_4, 0);
		fresh = ~shadow[address];
		u_memory.write_word(address, fresh);
		do_load(address, cpu_pkg::MEMW_4, 0);	// still the cached copy
		do_flush();
		shadow[address] = fresh;
		do_load(address, cpu_pkg::MEMW_4, 0);

		for (int n = 0; n < 6; n++)
			do_alu();

		$display("Regression passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/cpu_pkg.sv
rtl/cpu_lane_align.sv
rtl/cpu_memory_stage.sv
rtl/cpu_dcache.sv
rtl/cpu_memory_top.sv
test/tb_bus_memory.sv
test/tb_cpu_memory.sv
